// ==== rtl/s16b_pkg.sv ====
////////////////////////////////////////
// System 16B main CPU bus definitions
// Regions, size codes, I/O port codes
////////////////////////////////////////
package s16b_pkg;

    // Bus widths
    localparam int DATA_W   = 16;           // CPU data bus
    localparam int ADDR_W   = 23;           // Word address, bits 23:1
    localparam int RAM_AW   = 13;           // 8K words of work RAM
    localparam int N_REGION = 8;            // Mapper slots

    // Value seen on reads with no local source
    localparam logic [DATA_W-1:0] OPEN_BUS = 16'hFFFF;

    // Region index, also the bit position in active
    typedef enum logic [2:0] {
        REG_ROM0 = 3'd0,                    // Program ROM
        REG_ROM1 = 3'd1,
        REG_ROM2 = 3'd2,
        REG_WRAM = 3'd3,                    // 68000 work RAM
        REG_VRAM = 3'd4,                    // Text and tile RAM
        REG_OBJ  = 3'd5,                    // Sprite RAM
        REG_PAL  = 3'd6,                    // Colour RAM
        REG_IO   = 3'd7                     // Inputs and latch
    } s16b_region_e;

    // Slot size code, sets how many top bits are compared
    typedef enum logic [1:0] {
        SZ_64K  = 2'd0,                     // A23..A16
        SZ_128K = 2'd1,                     // A23..A17
        SZ_512K = 2'd2,                     // A23..A19
        SZ_2M   = 2'd3                      // A23..A21
    } s16b_size_e;

    // I/O sub-address on A13..A12
    typedef enum logic [1:0] {
        IO_JOY1  = 2'd0,
        IO_JOY2  = 2'd1,
        IO_DSW_A = 2'd2,
        IO_DSW_B = 2'd3
    } s16b_io_port_e;

endpackage

// ==== rtl/s16b_mem_map.sv ====
////////////////////////////////////////
// System 16B region mapper
// Eight programmable slots, one select each
////////////////////////////////////////
`timescale 1ns/100ps

module s16b_mem_map
    import s16b_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [ADDR_W:1]     addr,
    input  logic [DATA_W-1:0]   cpu_dout,
    input  logic [1:0]          dswn,      // Active low byte strobes
    output logic [N_REGION-1:0] active
);

    logic [N_REGION-1:0][7:0] base_q;       // Slot base, compared with A23..A16
    logic [N_REGION-1:0][1:0] size_q;       // Slot size code
    logic                     none;         // Address outside every region
    logic                     slot_we;
    logic [2:0]               slot;         // Slot picked by A4..A2

    assign none    = (active == '0);
    assign slot_we = none && !dswn[0];      // Only unmapped writes reach the mapper
    assign slot    = addr[4:2];

    // Region compare
    // Fewer address bits take part as the region grows
    always_comb begin
        for (int i = 0; i < N_REGION; i++) begin
            case (s16b_size_e'(size_q[i]))
                SZ_64K:  active[i] = (addr[23:16] == base_q[i]);
                SZ_128K: active[i] = (addr[23:17] == base_q[i][7:1]);
                SZ_512K: active[i] = (addr[23:19] == base_q[i][7:3]);
                SZ_2M:   active[i] = (addr[23:21] == base_q[i][7:5]);
                default: active[i] = 1'b0;
            endcase
        end
    end

    // Slot registers
    // Odd word loads the base, even word the size
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_q <= '0;                   // All slots decode the bottom 64 kB
            size_q <= '0;
        end else if (slot_we) begin
            if (addr[1]) begin
                base_q[slot] <= cpu_dout[7:0];
            end else begin
                size_q[slot] <= cpu_dout[1:0];  // Upper bits ignored
            end
        end
    end

    // A write that lands in some region must leave the map alone
    a_map_hold: assert property (
        @(posedge clk) disable iff (rst)
        ((dswn != 2'b11) && (active != '0)) |=> ($stable(base_q) && $stable(size_q))
    ) else $error("mapper slot changed during a mapped write");

endmodule

// ==== rtl/s16b_work_ram.sv ====
////////////////////////////////////////
// System 16B work RAM
// 8K x 16, byte writes, registered read
////////////////////////////////////////
`timescale 1ns/100ps

module s16b_work_ram
    import s16b_pkg::*;
(
    input  logic              clk,
    input  logic              cs,           // Region 3 select
    input  logic [RAM_AW:1]   addr,
    input  logic [DATA_W-1:0] cpu_dout,
    input  logic [1:0]        dswn,         // [1] upper byte, [0] lower byte
    output logic [DATA_W-1:0] q
);

    logic [DATA_W-1:0] mem [2**RAM_AW];     // No reset, contents undefined at start
    logic              we_hi;
    logic              we_lo;

    assign we_hi = cs && !dswn[1];
    assign we_lo = cs && !dswn[0];

    // Upper byte lane
    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[addr][15:8] <= cpu_dout[15:8];
        end
    end

    // Lower byte lane
    always_ff @(posedge clk) begin
        if (we_lo) begin
            mem[addr][7:0] <= cpu_dout[7:0];
        end
    end

    // Read every cycle, data valid one clock after the address
    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

    // A strobed write must carry a known address
    a_wr_addr_known: assert property (
        @(posedge clk) (we_hi || we_lo) |-> !$isunknown(addr)
    ) else $error("work RAM write with unknown address");

endmodule

// ==== rtl/s16b_io_regs.sv ====
////////////////////////////////////////
// System 16B I/O region
// Joystick and DIP reads, output latch
////////////////////////////////////////
`timescale 1ns/100ps

module s16b_io_regs
    import s16b_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,           // Region 7 select
    input  logic [13:12]      addr,         // Port select
    input  logic [1:0]        dswn,
    input  logic [7:0]        cpu_dout,     // Low data byte only
    input  logic [7:0]        joy1,
    input  logic [7:0]        joy2,
    input  logic [7:0]        dsw_a,
    input  logic [7:0]        dsw_b,
    output logic [DATA_W-1:0] q,
    output logic [7:0]        io_latch
);

    s16b_io_port_e port;
    logic [7:0]    port_val;                // Selected input byte
    logic          latch_we;

    assign port     = s16b_io_port_e'(addr);
    assign latch_we = cs && !dswn[0];       // Latch sits on the low byte lane

    always_comb begin
        case (port)
            IO_JOY1:  port_val = joy1;
            IO_JOY2:  port_val = joy2;
            IO_DSW_A: port_val = dsw_a;
            IO_DSW_B: port_val = dsw_b;
            default:  port_val = 8'hFF;
        endcase
    end

    // Read data one cycle after the address
    // Upper byte floats high on the board
    always_ff @(posedge clk) begin
        q <= {8'hFF, port_val};
    end

    // Output latch, lamps and coin counters on real hardware
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_latch <= '0;
        end else if (latch_we) begin
            io_latch <= cpu_dout;
        end
    end

endmodule

// ==== rtl/s16b_rd_mux.sv ====
////////////////////////////////////////
// System 16B read data mux and DTACK
// Lowest region wins, data registered
////////////////////////////////////////
`timescale 1ns/100ps

module s16b_rd_mux
    import s16b_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                asn,        // Address strobe, active low
    input  logic                rnw,        // High for read
    input  logic [N_REGION-1:0] active,
    input  logic [DATA_W-1:0]   ram_q,
    input  logic [DATA_W-1:0]   io_q,
    output logic [DATA_W-1:0]   cpu_din,
    output logic                dtackn
);

    logic              asn_q;               // Strobe one clock late
    logic              any_act;
    logic              ack_start;           // First acknowledged clock of a cycle
    s16b_region_e      win;                 // Lowest active region
    logic [DATA_W-1:0] rd_data;

    assign any_act   = |active;
    assign ack_start = !asn && !asn_q && dtackn && any_act;

    // Priority pick, scan from the top so the lowest index sticks
    always_comb begin
        win = REG_IO;
        for (int i = N_REGION - 1; i >= 0; i--) begin
            if (active[i]) win = s16b_region_e'(3'(i));
        end
    end

    always_comb begin
        case (win)
            REG_WRAM: rd_data = ram_q;
            REG_IO:   rd_data = io_q;
            default:  rd_data = OPEN_BUS;   // ROM and video memories live elsewhere
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            asn_q   <= 1'b1;
            dtackn  <= 1'b1;
            cpu_din <= OPEN_BUS;
        end else begin
            asn_q <= asn;
            if (asn) begin
                dtackn <= 1'b1;             // Release right after the strobe rises
            end else if (ack_start) begin
                dtackn <= 1'b0;
            end
            if (ack_start && rnw) cpu_din <= rd_data;  // Source data is ready by now
        end
    end

    // DTACK must follow the strobe back up within one clock
    a_dtack_release: assert property (
        @(posedge clk) disable iff (rst)
        (asn && $past(asn)) |-> dtackn
    ) else $error("dtackn low with asn high for two cycles");

endmodule

// ==== rtl/s16b_main_bus.sv ====
////////////////////////////////////////
// System 16B main CPU bus decoder
// Mapper, work RAM, I/O and read mux
////////////////////////////////////////
`timescale 1ns/100ps

module s16b_main_bus
    import s16b_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // CPU bus
    input  logic [ADDR_W:1]     addr,
    input  logic [DATA_W-1:0]   cpu_dout,
    input  logic                asn,
    input  logic                rnw,
    input  logic [1:0]          dswn,
    // Board inputs
    input  logic [7:0]          joy1,
    input  logic [7:0]          joy2,
    input  logic [7:0]          dsw_a,
    input  logic [7:0]          dsw_b,
    // Decoder outputs
    output logic [N_REGION-1:0] active,
    output logic [DATA_W-1:0]   cpu_din,
    output logic                dtackn,
    output logic [7:0]          io_latch
);

    logic [DATA_W-1:0] ram_q;               // Work RAM read word
    logic [DATA_W-1:0] io_q;                // I/O read word

    s16b_mem_map u_map (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .dswn     (dswn),
        .active   (active)
    );

    s16b_work_ram u_wram (
        .clk      (clk),
        .cs       (active[REG_WRAM]),
        .addr     (addr[RAM_AW:1]),         // 16 kB window
        .cpu_dout (cpu_dout),
        .dswn     (dswn),
        .q        (ram_q)
    );

    s16b_io_regs u_io (
        .clk      (clk),
        .rst      (rst),
        .cs       (active[REG_IO]),
        .addr     (addr[13:12]),
        .dswn     (dswn),
        .cpu_dout (cpu_dout[7:0]),
        .joy1     (joy1),
        .joy2     (joy2),
        .dsw_a    (dsw_a),
        .dsw_b    (dsw_b),
        .q        (io_q),
        .io_latch (io_latch)
    );

    s16b_rd_mux u_mux (
        .clk      (clk),
        .rst      (rst),
        .asn      (asn),
        .rnw      (rnw),
        .active   (active),
        .ram_q    (ram_q),
        .io_q     (io_q),
        .cpu_din  (cpu_din),
        .dtackn   (dtackn)
    );

endmodule

// ==== sim/tb_s16b_main_bus.sv ====
////////////////////////////////////////
// Testbench for the System 16B main bus
// Replays bus cycles from a stimulus file
////////////////////////////////////////
`timescale 1ns/100ps

module tb_s16b_main_bus
    import s16b_pkg::*;
();

    localparam     STIM_FILE  = "sim/s16b_stimulus.txt";
    localparam int RST_CYCLES = 5;
    localparam int ACK_WAIT   = 4;          // Clocks allowed for dtackn

    logic                clk = 1'b0;
    logic                rst;
    logic [ADDR_W:1]     addr;
    logic [DATA_W-1:0]   cpu_dout;
    logic                asn;
    logic                rnw;
    logic [1:0]          dswn;
    logic [7:0]          port_val [4];      // joy1, joy2, dsw_a, dsw_b as driven
    logic [N_REGION-1:0] active;
    logic [DATA_W-1:0]   cpu_din;
    logic                dtackn;
    logic [7:0]          io_latch;

    integer seed   = 1437;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit  = 0;                     // Known once the file is read

    always #5 clk = ~clk;

    s16b_main_bus dut0 (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .asn      (asn),
        .rnw      (rnw),
        .dswn     (dswn),
        .joy1     (port_val[0]),
        .joy2     (port_val[1]),
        .dsw_a    (port_val[2]),
        .dsw_b    (port_val[3]),
        .active   (active),
        .cpu_din  (cpu_din),
        .dtackn   (dtackn),
        .io_latch (io_latch)
    );

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout, run still going after %0d cycles", limit);
            $display("%0d errors in %0d checks", errors, checks);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        checks++;
        assert (got === want) else begin
            $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    task automatic check_ack(input logic acked, input logic want_ack);
        checks++;
        if (want_ack) begin
            assert (acked) else begin
                $display("No data acknowledge within %0d clocks at 0x%h", ACK_WAIT, {addr, 1'b0});
                errors++;
            end
        end else begin
            assert (!acked) else begin
                $display("Data acknowledge on an unmapped access at 0x%h", {addr, 1'b0});
                errors++;
            end
        end
    endtask

    // Lower the strobe and wait a bounded time for dtackn
    task automatic bus_start(input logic [23:0] baddr, input logic [15:0] data,
                             input logic wr, input logic [1:0] lanes, output logic acked);
        int n;
        addr     = baddr[23:1];
        cpu_dout = data;
        rnw      = !wr;
        dswn     = wr ? ~lanes : 2'b11;     // Strobes only on writes
        asn      = 1'b0;
        acked    = 1'b0;
        n        = 0;
        while (!acked && n < ACK_WAIT) begin
            @(negedge clk);
            acked = !dtackn;
            n++;
        end
    endtask

    task automatic bus_end();
        asn  = 1'b1;
        dswn = 2'b11;
        rnw  = 1'b1;
        @(negedge clk);                     // dtackn back high by now
        check_value("dtackn", 16'(dtackn), 16'h0001);
    endtask

    task automatic run_line(input string line);
        logic [7:0]  op;
        logic [23:0] baddr;                 // Byte address
        logic [15:0] data;
        logic [3:0]  mask;
        logic [15:0] want;
        logic        acked;
        int          n;
        n = $sscanf(line, "%c %h %h %h %h", op, baddr, data, mask, want);
        assert (n == 5) else begin
            $display("Stimulus line could not be parsed: %s", line);
            errors++;
        end
        if (n == 5) begin
            case (op)
                "A": begin
                    addr = baddr[23:1];
                    @(negedge clk);         // Decode settled
                    check_value("active", 16'(active), want);
                end
                "P": port_val[baddr[1:0]] = mask[0] ? 8'($random(seed)) : data[7:0];
                "W", "R": begin
                    bus_start(baddr, data, op == "W", mask[1:0], acked);
                    check_ack(acked, mask[2]);
                    if (op == "R" && acked) begin
                        if (mask[0]) want = {8'hFF, port_val[baddr[13:12]]};  // Live port
                        check_value("cpu_din", cpu_din, want);
                    end
                    bus_end();
                    if (op == "W") check_value("io_latch", 16'(io_latch), want);
                end
                default: begin
                    assert (0) else begin
                        $display("Unknown operation in line: %s", line);
                        errors++;
                    end
                end
            endcase
        end
    endtask

    initial begin
        int    fd;
        string line;
        string lines[$];
        rst      = 1'b1;
        addr     = '0;
        cpu_dout = '0;
        asn      = 1'b1;
        rnw      = 1'b1;
        dswn     = 2'b11;
        for (int i = 0; i < 4; i++) port_val[i] = 8'h00;
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else begin
            $display("Stimulus file could not be opened");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            if ($fgets(line, fd) != 0) lines.push_back(line);
        end
        if (fd != 0) $fclose(fd);
        limit = lines.size() * 8 + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("dtackn", 16'(dtackn), 16'h0001);       // State left by reset
        check_value("cpu_din", cpu_din, OPEN_BUS);
        check_value("io_latch", 16'(io_latch), 16'h0000);
        foreach (lines[i]) begin
            line = lines[i];
            if (line.len() > 1 && line.getc(0) != "#") run_line(line);  // Skip notes
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) $display("ALL CHECKS PASSED");
        else $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sim/s16b_stimulus.txt ====
# op byte_addr data mask expect (hex). mask[1:0] write lanes, mask[2] dtackn expected
# W expect is io_latch after the cycle, R expect is cpu_din, A expect is active
# R mask[0] takes the driven port value, P addr is the port code, P mask[0] random
A 000000 0000 0 FF
A F00000 0000 0 00
W F00000 0002 1 00
A 07FFFE 0000 0 01
A 080000 0000 0 00
W F00008 0002 1 00
W F0000A 0010 1 00
A 17FFFE 0000 0 04
A 180000 0000 0 00
W F0000E 00FF 1 00
A FF0000 0000 0 08
W F00010 0001 1 00
W F00012 0041 1 00
A 400000 0000 0 10
A 420000 0000 0 00
W F00018 0003 1 00
W F0001A 0084 1 00
A 9FFFFE 0000 0 40
A A00000 0000 0 00
W F0001E 00C4 1 00
A C43000 0000 0 80
A 000000 0000 0 23
W 000006 0020 5 00
A 200000 0000 0 00
A 000000 0000 0 23
W FFC000 1234 7 00
W FFC000 00AB 5 00
R FFC000 0000 4 12AB
W FFC000 CD00 6 00
R FF0000 0000 4 CDAB
P 000000 0000 1 00
P 000001 0000 1 00
P 000002 005A 0 00
R C40000 0000 5 0000
R C41000 0000 5 0000
R C42000 0000 4 FF5A
W C40000 0096 5 96
W C40000 7700 6 96
R 400000 0000 4 FFFF
W F0001E 00FF 1 96
A FFC000 0000 0 88
R FFC000 0000 4 CDAB
R 200000 0000 0 0000
W 300000 1111 2 96

// ==== list.f ====
rtl/s16b_pkg.sv
rtl/s16b_mem_map.sv
rtl/s16b_work_ram.sv
rtl/s16b_io_regs.sv
rtl/s16b_rd_mux.sv
rtl/s16b_main_bus.sv
sim/tb_s16b_main_bus.sv
